/* spidergon_node.f */
+incdir+testbench
source/noc_flit_pkg.sv
source/spidergon_topology_pkg.sv
source/rr_arbiter.sv
source/vc_fifo.sv
source/input_port.sv
source/cpu_eject_arbiter.sv
source/inject_router.sv
source/spidergon_node.sv
testbench/tb_spidergon_node.sv

/* Bender.yml */
package:
  name: spidergon_node

sources:
  - source/noc_flit_pkg.sv
  - source/spidergon_topology_pkg.sv
  - source/rr_arbiter.sv
  - source/vc_fifo.sv
  - source/input_port.sv
  - source/cpu_eject_arbiter.sv
  - source/inject_router.sv
  - source/spidergon_node.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_spidergon_node.sv

/* testbench/tb_node_model.svh */
// reference model with the ejection queues, the expected link outputs and the routing rule
`ifndef TB_NODE_MODEL_SVH
`define TB_NODE_MODEL_SVH

// flits still owed to the CPU, one queue per arrival port and sender channel
noc_flit_pkg::flit_t eject_q [3][2][$];

// link output expected for the flit driven this cycle and for the one already sampled
spidergon_topology_pkg::direction_e exp_dir_next;
spidergon_topology_pkg::direction_e exp_dir_now;
noc_flit_pkg::flit_t exp_flit_next;
noc_flit_pkg::flit_t exp_flit_now;

// the shorter way around the ring wins when it is at most a quarter of the ring
function automatic spidergon_topology_pkg::direction_e pick_direction(int dest);
	int cw_hops;
	int acw_hops;
	cw_hops = (dest - node_id + num_nodes) % num_nodes;
	acw_hops = num_nodes - cw_hops;
	if (cw_hops == 0)
		return spidergon_topology_pkg::dir_stop;
	if (cw_hops * 4 <= num_nodes)
		return spidergon_topology_pkg::dir_clockwise;
	if (acw_hops * 4 <= num_nodes)
		return spidergon_topology_pkg::dir_anticlockwise;
	return spidergon_topology_pkg::dir_across;
endfunction

// number of flits that were accepted on a ring port and have not been ejected yet
function automatic int owed_flits();
	int total;
	total = 0;
	for (int p = 0; p < 3; p++)
		for (int s = 0; s < 2; s++)
			total += eject_q[p][s].size();
	return total;
endfunction

// the port whose oldest flit for this sender channel equals the ejected flit, or -1
function automatic int owner_port(noc_flit_pkg::flit_t flit);
	for (int p = 0; p < 3; p++)
	begin
		if (eject_q[p][int'(flit.vc)].size() != 0 && eject_q[p][int'(flit.vc)][0] == flit)
			return p;
	end
	return -1;
endfunction

`endif

/* testbench/tb_spidergon_node.sv */
// testbench for one spidergon node with random ring and CPU traffic, compare tasks and report
module tb_spidergon_node;

	localparam int num_nodes = 8;
	localparam int node_id = 0;
	localparam int buffer_depth = 2;
	localparam int stim_cycles = 4000;
	localparam int drain_limit = 600;

	logic clk;
	logic reset;
	logic cpu_ready;
	noc_flit_pkg::flit_t link_in [3];
	logic [2:0] link_in_valid;
	noc_flit_pkg::flit_t cpu_in;
	logic cpu_in_valid;
	logic [2:0][1:0] vc_free;
	logic [2:0][1:0] vc_full;
	noc_flit_pkg::flit_t cpu_out;
	logic cpu_out_valid;
	spidergon_topology_pkg::ring_port_e cpu_out_port;
	noc_flit_pkg::flit_t link_out [3];
	logic [2:0] link_out_valid;

	int value_errors;
	int other_errors;
	logic checking;
	logic stopping;
	// what the last rising edge saw, read back by the checker at the falling edge
	logic ready_at_edge;
	logic [2:0] head_at_edge;
	// DUT flow control as seen at the last falling edge
	logic [2:0][1:0] free_snap;
	logic [2:0][1:0] full_snap;
	// upstream senders, one open packet at most per port and sender channel
	logic open_pkt [3][2];
	int bodies_left [3][2];
	int seq_no [3];
	logic cpu_open;
	int cpu_bodies_left;
	spidergon_topology_pkg::direction_e cpu_dir;

	`include "tb_node_model.svh"

	spidergon_node #(.num_nodes(num_nodes), .node_id(node_id), .buffer_depth(buffer_depth)) dut0
	(
		.clk(clk), .reset(reset), .cpu_ready(cpu_ready),
		.link_in(link_in), .link_in_valid(link_in_valid),
		.cpu_in(cpu_in), .cpu_in_valid(cpu_in_valid),
		.vc_free(vc_free), .vc_full(vc_full),
		.cpu_out(cpu_out), .cpu_out_valid(cpu_out_valid), .cpu_out_port(cpu_out_port),
		.link_out(link_out), .link_out_valid(link_out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic check_flit(string name, noc_flit_pkg::flit_t got, noc_flit_pkg::flit_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_port(string name, spidergon_topology_pkg::ring_port_e got,
		spidergon_topology_pkg::ring_port_e exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("Fail at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// the ejected flit must be the oldest one owed for its sender channel on some port
	task automatic check_ejection();
		int p;
		p = owner_port(cpu_out);
		if (p < 0)
		begin
			other_errors++;
			$display("at %0t the CPU got flit %h, which no port owes next", $time, cpu_out);
		end
		else
		begin
			check_port("cpu_out_port", cpu_out_port, spidergon_topology_pkg::ring_port_e'(p));
			void'(eject_q[p][int'(cpu_out.vc)].pop_front());
		end
	endtask

	// a port sends at most every other cycle, so the snapshot never overstates room
	task automatic drive_ring(int p, logic allow_new);
		int s;
		noc_flit_pkg::flit_t f;
		s = $urandom_range(1);
		link_in_valid[p] <= 1'b0;
		if (link_in_valid[p] || $urandom_range(1) == 0)
			return;
		f.vc = noc_flit_pkg::vc_t'(s);
		// the port number and a sequence count make every flit unique
		f.body = {3'($urandom_range(7)), 2'(p), 10'(seq_no[p])};
		if (open_pkt[p][s])
		begin
			if (full_snap[p] != '0)
				return;
			if (bodies_left[p][s] == 0)
			begin
				f.kind = noc_flit_pkg::flit_tail;
				open_pkt[p][s] = 1'b0;
			end
			else
			begin
				f.kind = noc_flit_pkg::flit_body;
				bodies_left[p][s]--;
			end
		end
		else
		begin
			if (!allow_new || free_snap[p] == '0)
				return;
			f.kind = ($urandom_range(3) == 0) ? noc_flit_pkg::flit_header : noc_flit_pkg::flit_head;
			open_pkt[p][s] = (f.kind == noc_flit_pkg::flit_head);
			bodies_left[p][s] = $urandom_range(3);
		end
		link_in[p] <= f;
		link_in_valid[p] <= 1'b1;
		seq_no[p]++;
		eject_q[p][s].push_back(f);
	endtask

	// CPU packets, the head picks the direction and the rest of the packet keeps it
	task automatic drive_cpu(logic allow_new);
		int dest;
		noc_flit_pkg::flit_t f;
		cpu_in_valid <= 1'b0;
		exp_dir_next = spidergon_topology_pkg::dir_stop;
		if ($urandom_range(1) == 0)
			return;
		dest = $urandom_range(num_nodes - 1);
		f.vc = noc_flit_pkg::vc_t'($urandom_range(1));
		f.body = {3'(dest), 12'($urandom)};
		if (cpu_open)
		begin
			if (cpu_bodies_left == 0)
			begin
				f.kind = noc_flit_pkg::flit_tail;
				cpu_open = 1'b0;
			end
			else
			begin
				f.kind = noc_flit_pkg::flit_body;
				cpu_bodies_left--;
			end
		end
		else
		begin
			if (!allow_new)
				return;
			f.kind = ($urandom_range(3) == 0) ? noc_flit_pkg::flit_header : noc_flit_pkg::flit_head;
			cpu_open = (f.kind == noc_flit_pkg::flit_head);
			cpu_bodies_left = $urandom_range(3);
			cpu_dir = pick_direction(dest);
		end
		cpu_in <= f;
		cpu_in_valid <= 1'b1;
		exp_dir_next = cpu_dir;
		exp_flit_next = f;
	endtask

	task automatic drive_cycle(logic allow_new);
		@(posedge clk);
		checking = 1'b1;
		ready_at_edge = cpu_ready;
		exp_dir_now = exp_dir_next;
		exp_flit_now = exp_flit_next;
		for (int p = 0; p < 3; p++)
		begin
			head_at_edge[p] = link_in_valid[p] && (link_in[p].kind == noc_flit_pkg::flit_head);
			drive_ring(p, allow_new);
		end
		cpu_ready <= stopping || ($urandom_range(3) != 0);
		drive_cpu(allow_new);
	endtask

	function automatic logic senders_idle();
		logic idle;
		idle = !cpu_open;
		for (int p = 0; p < 3; p++)
			for (int s = 0; s < 2; s++)
				idle = idle && !open_pkt[p][s];
		return idle;
	endfunction

	// outputs are settled at the falling edge, halfway between two driving edges
	always @(negedge clk)
	begin
		free_snap = vc_free;
		full_snap = vc_full;
		if (checking)
		begin
			if (!ready_at_edge)
				check_bit("cpu_out_valid while not ready", cpu_out_valid, 1'b0);
			if (cpu_out_valid)
				check_ejection();
			for (int p = 0; p < 3; p++)
			begin
				check_bit($sformatf("link_out_valid[%0d]", p), link_out_valid[p],
					int'(exp_dir_now) == p);
				if (int'(exp_dir_now) == p)
					check_flit($sformatf("link_out[%0d]", p), link_out[p], exp_flit_now);
				// the channel a head claimed is busy, so both bits cannot be high
				if (head_at_edge[p])
					check_bit($sformatf("vc_free[%0d] both high after head", p), &vc_free[p], 1'b0);
			end
		end
	end

	task automatic finish_run();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	initial
	begin
		int wait_cycles;
		void'($urandom(20122));
		reset = 1'b1;
		cpu_ready = 1'b0;
		link_in_valid = '0;
		cpu_in = '0;
		cpu_in_valid = 1'b0;
		for (int p = 0; p < 3; p++)
		begin
			link_in[p] = '0;
			seq_no[p] = 0;
			for (int s = 0; s < 2; s++)
			begin
				open_pkt[p][s] = 1'b0;
				bodies_left[p][s] = 0;
			end
		end
		value_errors = 0;
		other_errors = 0;
		checking = 1'b0;
		stopping = 1'b0;
		ready_at_edge = 1'b0;
		head_at_edge = '0;
		free_snap = '0;
		full_snap = '0;
		cpu_open = 1'b0;
		cpu_bodies_left = 0;
		cpu_dir = spidergon_topology_pkg::dir_stop;
		exp_dir_next = spidergon_topology_pkg::dir_stop;
		exp_dir_now = spidergon_topology_pkg::dir_stop;
		exp_flit_next = '0;
		exp_flit_now = '0;
		repeat (3)
			@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// state straight out of reset
		for (int p = 0; p < 3; p++)
		begin
			check_bit($sformatf("vc_free[%0d] after reset", p), &vc_free[p], 1'b1);
			check_bit($sformatf("vc_full[%0d] after reset", p), |vc_full[p], 1'b0);
			check_bit($sformatf("link_out_valid[%0d] after reset", p), link_out_valid[p], 1'b0);
		end
		check_bit("cpu_out_valid after reset", cpu_out_valid, 1'b0);
		for (int c = 0; c < stim_cycles; c++)
			drive_cycle(1'b1);
		// close the open packets and let the CPU take everything that is still buffered
		stopping = 1'b1;
		wait_cycles = 0;
		while ((owed_flits() != 0 || !senders_idle()) && wait_cycles < drain_limit)
		begin
			drive_cycle(1'b0);
			wait_cycles++;
		end
		drive_cycle(1'b0);
		@(negedge clk);
		if (owed_flits() != 0 || !senders_idle())
		begin
			other_errors++;
			$display("timed out with %0d flits never ejected to the CPU", owed_flits());
		end
		else
		begin
			for (int p = 0; p < 3; p++)
			begin
				check_bit($sformatf("vc_free[%0d] after drain", p), &vc_free[p], 1'b1);
				check_bit($sformatf("vc_full[%0d] after drain", p), |vc_full[p], 1'b0);
			end
		end
		finish_run();
	end

endmodule

/* source/spidergon_node.sv */
// one spidergon node with three ring input ports, CPU ejection and CPU injection routing
module spidergon_node
#(
	parameter int num_nodes = 8,
	parameter int node_id = 0,
	parameter int buffer_depth = 2
)
(
	input logic clk,
	input logic reset,
	input logic cpu_ready,
	input noc_flit_pkg::flit_t link_in [spidergon_topology_pkg::ring_port_count],
	input logic [spidergon_topology_pkg::ring_port_count-1:0] link_in_valid,
	input noc_flit_pkg::flit_t cpu_in,
	input logic cpu_in_valid,
	output logic [spidergon_topology_pkg::ring_port_count-1:0][noc_flit_pkg::vc_count-1:0] vc_free,
	output logic [spidergon_topology_pkg::ring_port_count-1:0][noc_flit_pkg::vc_count-1:0] vc_full,
	output noc_flit_pkg::flit_t cpu_out,
	output logic cpu_out_valid,
	output spidergon_topology_pkg::ring_port_e cpu_out_port,
	output noc_flit_pkg::flit_t link_out [spidergon_topology_pkg::ring_port_count],
	output logic [spidergon_topology_pkg::ring_port_count-1:0] link_out_valid
);

	localparam int ports = spidergon_topology_pkg::ring_port_count;
	localparam int vcs = noc_flit_pkg::vc_count;

	// request, grant and head flit of every channel between the ports and the ejection
	logic [ports-1:0][vcs-1:0] eject_req;
	logic [ports-1:0][vcs-1:0] eject_grant;
	noc_flit_pkg::flit_t eject_flit [ports][vcs];

	// port index follows ring_port_e, so anticlockwise is port 0
	for (genvar p = 0; p < ports; p++)
	begin : g_port
		input_port #(.buffer_depth(buffer_depth)) port
		(
			.clk(clk),
			.reset(reset),
			.flit_in(link_in[p]),
			.flit_valid(link_in_valid[p]),
			.eject_grant(eject_grant[p]),
			.eject_req(eject_req[p]),
			.eject_flit(eject_flit[p]),
			.vc_free(vc_free[p]),
			.vc_full(vc_full[p])
		);
	end

	// the three ports share the single path to the CPU
	cpu_eject_arbiter eject
	(
		.clk(clk),
		.reset(reset),
		.cpu_ready(cpu_ready),
		.eject_req(eject_req),
		.eject_flit(eject_flit),
		.eject_grant(eject_grant),
		.cpu_out(cpu_out),
		.cpu_out_valid(cpu_out_valid),
		.cpu_out_port(cpu_out_port)
	);

	inject_router #(.num_nodes(num_nodes), .node_id(node_id)) router
	(
		.clk(clk),
		.reset(reset),
		.cpu_in(cpu_in),
		.cpu_in_valid(cpu_in_valid),
		.link_out(link_out),
		.link_out_valid(link_out_valid)
	);

endmodule

/* source/inject_router.sv */
// route computation for CPU flits with the held packet direction and the output link registers
module inject_router
#(
	parameter int num_nodes = 8,
	parameter int node_id = 0
)
(
	input logic clk,
	input logic reset,
	input noc_flit_pkg::flit_t cpu_in,
	input logic cpu_in_valid,
	output noc_flit_pkg::flit_t link_out [spidergon_topology_pkg::ring_port_count],
	output logic [spidergon_topology_pkg::ring_port_count-1:0] link_out_valid
);

	localparam int ports = spidergon_topology_pkg::ring_port_count;

	logic head_in;
	logic packet_open;
	spidergon_topology_pkg::direction_e held_dir;
	spidergon_topology_pkg::direction_e new_dir;

	// a head picks the direction, everything after it follows the held one
	always_comb
	begin
		head_in = (cpu_in.kind == noc_flit_pkg::flit_head) ||
			(cpu_in.kind == noc_flit_pkg::flit_header);
		if (head_in)
			new_dir = spidergon_topology_pkg::route(noc_flit_pkg::dest_of(cpu_in),
				node_id, num_nodes);
		else
			new_dir = held_dir;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			packet_open <= 1'b0;
			held_dir <= spidergon_topology_pkg::dir_stop;
			link_out_valid <= '0;
		end
		else
		begin
			// stop matches no port, so flits for this node leave nothing behind
			for (int p = 0; p < ports; p++)
				link_out_valid[p] <= cpu_in_valid && (int'(new_dir) == p) &&
					(head_in || packet_open);
			if (cpu_in_valid)
			begin
				if (head_in)
					held_dir <= new_dir;
				// open after a head, kept by body, closed by tail and header
				packet_open <= (cpu_in.kind == noc_flit_pkg::flit_head) ||
					((cpu_in.kind == noc_flit_pkg::flit_body) && packet_open);
			end
		end
	end

	// only the selected link register loads the flit
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < ports; p++)
		begin
			if (cpu_in_valid && (int'(new_dir) == p))
				link_out[p] <= cpu_in;
		end
	end

	// the CPU must not send body or tail flits outside a packet
	a_packet_open: assert property (@(posedge clk) disable iff (reset)
		cpu_in_valid && !head_in |-> packet_open);

endmodule

/* source/cpu_eject_arbiter.sv */
// two-level port and channel arbitration feeding the registered CPU output
module cpu_eject_arbiter
(
	input logic clk,
	input logic reset,
	input logic cpu_ready,
	input logic [spidergon_topology_pkg::ring_port_count-1:0][noc_flit_pkg::vc_count-1:0] eject_req,
	input noc_flit_pkg::flit_t eject_flit
		[spidergon_topology_pkg::ring_port_count][noc_flit_pkg::vc_count],
	output logic [spidergon_topology_pkg::ring_port_count-1:0][noc_flit_pkg::vc_count-1:0] eject_grant,
	output noc_flit_pkg::flit_t cpu_out,
	output logic cpu_out_valid,
	output spidergon_topology_pkg::ring_port_e cpu_out_port
);

	localparam int ports = spidergon_topology_pkg::ring_port_count;
	localparam int vcs = noc_flit_pkg::vc_count;

	logic [ports-1:0] port_req;
	logic [ports-1:0] port_grant;
	logic [ports-1:0][vcs-1:0] vc_req;
	noc_flit_pkg::flit_t win_flit;
	spidergon_topology_pkg::ring_port_e win_port;

	// the CPU ready level masks the port requests, so no pointer moves while it is low
	for (genvar p = 0; p < ports; p++)
	begin : g_port_req
		assign port_req[p] = cpu_ready && (|eject_req[p]);
		// only the winning port lets its channels compete
		assign vc_req[p] = port_grant[p] ? eject_req[p] : '0;
	end

	rr_arbiter #(.width(ports)) port_arb
	(
		.clk(clk),
		.reset(reset),
		.req(port_req),
		.grant(port_grant)
	);

	// each port keeps its own channel pointer, so fairness holds inside every port
	for (genvar p = 0; p < ports; p++)
	begin : g_vc_arb
		rr_arbiter #(.width(vcs)) vc_arb
		(
			.clk(clk),
			.reset(reset),
			.req(vc_req[p]),
			.grant(eject_grant[p])
		);
	end

	// the granted head flit and the port it came through
	always_comb
	begin
		win_flit = eject_flit[0][0];
		win_port = spidergon_topology_pkg::port_anticlockwise;
		for (int p = 0; p < ports; p++)
		begin
			for (int v = 0; v < vcs; v++)
			begin
				if (eject_grant[p][v])
				begin
					win_flit = eject_flit[p][v];
					win_port = spidergon_topology_pkg::ring_port_e'(p);
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			cpu_out_valid <= 1'b0;
		else
			cpu_out_valid <= |port_grant;
	end

	// the flit keeps its vc field, the port is reported beside it
	always_ff @(posedge clk)
	begin
		if (|port_grant)
		begin
			cpu_out <= win_flit;
			cpu_out_port <= win_port;
		end
	end

	// one dequeue per cycle over all ports, and never while the CPU is not ready
	a_single_eject: assert property (@(posedge clk) disable iff (reset)
		$onehot0(eject_grant) && (cpu_ready || (eject_grant == '0)));

endmodule

/* source/input_port.sv */
// ring input port with two channel buffers, the reservation table and the claim arbiter
module input_port
#(
	parameter int buffer_depth = 2
)
(
	input logic clk,
	input logic reset,
	input noc_flit_pkg::flit_t flit_in,
	input logic flit_valid,
	input logic [noc_flit_pkg::vc_count-1:0] eject_grant,
	output logic [noc_flit_pkg::vc_count-1:0] eject_req,
	output noc_flit_pkg::flit_t eject_flit [noc_flit_pkg::vc_count],
	output logic [noc_flit_pkg::vc_count-1:0] vc_free,
	output logic [noc_flit_pkg::vc_count-1:0] vc_full
);

	localparam int vcs = noc_flit_pkg::vc_count;
	localparam int pend_width = $clog2(buffer_depth + 1);

	logic head_in;
	logic [vcs-1:0] claim_grant;
	logic [vcs-1:0] match;
	logic [vcs-1:0] push;
	logic [vcs-1:0] empty;
	logic [vcs-1:0] stale;
	// reservation table, one row per local channel
	logic [vcs-1:0] busy;
	noc_flit_pkg::vc_t sender [vcs];
	// buffered flits per local channel and per sender channel
	logic [pend_width-1:0] pending [vcs][vcs];

	// head and header both open a new reservation
	assign head_in = (flit_in.kind == noc_flit_pkg::flit_head) ||
		(flit_in.kind == noc_flit_pkg::flit_header);

	// a head asks for any free channel, the arbiter spreads heads over both
	rr_arbiter #(.width(vcs)) claim_arb
	(
		.clk(clk),
		.reset(reset),
		.req(vc_free & {vcs{flit_valid && head_in}}),
		.grant(claim_grant)
	);

	always_comb
	begin
		for (int i = 0; i < vcs; i++)
		begin
			// body and tail flits find the row that their sender channel opened
			match[i] = busy[i] && (sender[i] == flit_in.vc);
			push[i] = flit_valid && !vc_full[i] && (head_in ? claim_grant[i] : match[i]);
			// leftover flits of a closed packet, or older flits below the current owner
			stale[i] = 1'b0;
			for (int s = 0; s < vcs; s++)
			begin
				if ((pending[i][s] != '0) &&
					!(busy[i] && (sender[i] == noc_flit_pkg::vc_t'(s))))
					stale[i] = 1'b1;
			end
		end
		// a channel is offered only while no other channel holds leftovers
		// which keeps each sender channel in arrival order across packets
		for (int i = 0; i < vcs; i++)
		begin
			vc_free[i] = !busy[i] && !vc_full[i];
			for (int k = 0; k < vcs; k++)
			begin
				if (k != i && stale[k])
					vc_free[i] = 1'b0;
			end
		end
	end

	for (genvar i = 0; i < vcs; i++)
	begin : g_vc
		vc_fifo #(.depth(buffer_depth)) fifo
		(
			.clk(clk),
			.reset(reset),
			.push(push[i]),
			.pop(eject_grant[i]),
			.push_flit(flit_in),
			.pop_flit(eject_flit[i]),
			.empty(empty[i]),
			.full(vc_full[i])
		);
	end

	assign eject_req = ~empty;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= '0;
			for (int i = 0; i < vcs; i++)
			begin
				sender[i] <= '0;
				for (int s = 0; s < vcs; s++)
					pending[i][s] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < vcs; i++)
			begin
				if (push[i] && head_in)
					sender[i] <= flit_in.vc;
				// the row stays busy through the body and is released by tail or header
				if (push[i])
					busy[i] <= (flit_in.kind == noc_flit_pkg::flit_head) ||
						(flit_in.kind == noc_flit_pkg::flit_body);
				for (int s = 0; s < vcs; s++)
				begin
					case ({push[i] && (flit_in.vc == noc_flit_pkg::vc_t'(s)),
						eject_grant[i] && (eject_flit[i].vc == noc_flit_pkg::vc_t'(s))})
						2'b10: pending[i][s] <= pending[i][s] + 1'b1;
						2'b01: pending[i][s] <= pending[i][s] - 1'b1;
						default: pending[i][s] <= pending[i][s];
					endcase
				end
			end
		end
	end

	// the upstream node may only send a head while vc_free shows room
	a_head_has_room: assert property (@(posedge clk) disable iff (reset)
		flit_valid && head_in |-> |vc_free);
	// body and tail need an open reservation whose buffer is not full
	a_body_reserved: assert property (@(posedge clk) disable iff (reset)
		flit_valid && !head_in |-> (|match) && ((match & vc_full) == '0));

endmodule

/* source/vc_fifo.sv */
// first-in first-out flit buffer of one virtual channel
module vc_fifo
#(
	parameter int depth = 2
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input noc_flit_pkg::flit_t push_flit,
	output noc_flit_pkg::flit_t pop_flit,
	output logic empty,
	output logic full
);

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_width = $clog2(depth + 1);

	noc_flit_pkg::flit_t mem [depth];
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width-1:0] wr_ptr;
	logic [count_width-1:0] count;

	// pointers step through the array and wrap after the last slot
	function automatic logic [ptr_width-1:0] next_ptr(logic [ptr_width-1:0] ptr);
		if (ptr == ptr_width'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// oldest flit is always visible, so the consumer can look before it pops
	assign pop_flit = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == count_width'(depth));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// a push and a pop on the same edge leave the fill level unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage is written only where the write pointer stands
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_flit;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

/* source/rr_arbiter.sv */
// round-robin arbiter with a rotating priority pointer and a one-hot grant
module rr_arbiter
#(
	parameter int width = 2
)
(
	input logic clk,
	input logic reset,
	input logic [width-1:0] req,
	output logic [width-1:0] grant
);

	localparam int ptr_width = (width > 1) ? $clog2(width) : 1;

	// index of the requester with the highest priority in this cycle
	logic [ptr_width-1:0] ptr;
	logic [ptr_width-1:0] ptr_next;

	// scan from the pointer and wrap around, the first request found wins
	always_comb
	begin
		int idx;
		logic found;
		grant = '0;
		ptr_next = ptr;
		found = 1'b0;
		for (int i = 0; i < width; i++)
		begin
			idx = (int'(ptr) + i) % width;
			if (!found && req[idx])
			begin
				found = 1'b1;
				grant[idx] = 1'b1;
				// the winner drops to lowest priority on the next round
				ptr_next = ptr_width'((idx + 1) % width);
			end
		end
	end

	// pointer only moves when somebody was granted
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else
			ptr <= ptr_next;
	end

	a_grant_legal: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant) && ((grant & ~req) == '0));

endmodule

/* source/spidergon_topology_pkg.sv */
// ring port enum, routing direction enum and the spidergon routing function
package spidergon_topology_pkg;

	// every node has the same three ring neighbours
	localparam int ring_port_count = 3;

	// one index for both sides: the port a flit arrived on and the port it leaves by
	typedef enum logic [1:0]
	{
		port_anticlockwise = 2'd0,
		port_clockwise = 2'd1,
		port_across = 2'd2
	} ring_port_e;

	// same encoding as ring_port_e, with stop for flits that end at this node
	typedef enum logic [1:0]
	{
		dir_anticlockwise = 2'd0,
		dir_clockwise = 2'd1,
		dir_across = 2'd2,
		dir_stop = 2'd3
	} direction_e;

	// distance is measured clockwise from this node to the destination
	function automatic direction_e route(int unsigned dest, int unsigned node,
		int unsigned node_count);
		int unsigned rel;
		rel = (dest + node_count - node) % node_count;
		// near neighbours go around the ring and the far half goes across
		if (rel == 0)
			return dir_stop;
		else if (4 * rel <= node_count)
			return dir_clockwise;
		else if (4 * rel >= 3 * node_count)
			return dir_anticlockwise;
		return dir_across;
	endfunction

endpackage

/* source/noc_flit_pkg.sv */
// flit type enum, flit layout struct, flit field widths and the destination helper
package noc_flit_pkg;

	// payload width that follows the two type bits of every flit
	localparam int flit_data_width = 16;

	// two virtual channels on every ring input port
	localparam int vc_count = 2;

	// three bits of node index cover a ring of eight nodes
	localparam int node_id_width = 3;

	// header is a head that is also its own tail, so it opens and closes a packet at once
	typedef enum logic [1:0]
	{
		flit_tail = 2'b00,
		flit_head = 2'b01,
		flit_body = 2'b10,
		flit_header = 2'b11
	} flit_type_e;

	typedef logic [0:0] vc_t;
	typedef logic [node_id_width-1:0] node_id_t;

	// vc names the channel that the sender used, body fills the rest of the payload
	typedef struct packed
	{
		flit_type_e kind;
		vc_t vc;
		logic [flit_data_width-$bits(vc_t)-1:0] body;
	} flit_t;

	// head and header flits carry the destination in the top bits of the body
	function automatic node_id_t dest_of(flit_t flit);
		return flit.body[$bits(flit.body)-1 -: node_id_width];
	endfunction

endpackage
